// File: src/mk14_pkg.sv
// Shared types, address map, key hold time and FSM encodings for the MK14 loader and keypad

`default_nettype none

package mk14_pkg;

	typedef logic [15:0] addr_t;	// System address
	typedef logic [7:0] byte_t;
	typedef logic [2:0] kbd_row_t;	// Keypad row 0 to 7
	typedef logic [2:0] kbd_bit_t;	// Bit within a row
	typedef logic [7:0] ir_code_t;	// Remote command byte

	localparam addr_t RAM_BASE = 16'h0F00;	// Standard RAM
	localparam addr_t RAM_SIZE = 16'd256;
	localparam addr_t KBD_BASE = 16'h0D00;	// Keypad rows
	localparam addr_t KBD_ROWS = 16'd8;

	localparam int KEY_HOLD_CYCLES = 16;

	// Intel HEX record fields in arrival order
	typedef enum logic [2:0] {
		IH_SCAN,
		IH_COUNT,
		IH_ADDR_HI,
		IH_ADDR_LO,
		IH_TYPE,
		IH_DATA,
		IH_CSUM,
		IH_DONE
	} ihex_state_e;

	typedef enum logic [1:0] {
		KEY_IDLE,
		KEY_PRESS,
		KEY_HOLD
	} key_state_e;

endpackage

`default_nettype wire

// File: src/ihex_loader.sv
// Intel HEX text parser; turns a framed character stream into RAM writes until end of file

`default_nettype none
`timescale 1ns/1ps

module ihex_loader (
	input wire logic clk,
	input wire logic soft_reset,
	input wire mk14_pkg::byte_t i_rx_data,
	input wire logic i_rx_valid,
	output logic o_wr_en,
	output mk14_pkg::addr_t o_wr_addr,
	output mk14_pkg::byte_t o_wr_data,
	output logic o_loading,
	output logic o_load_error,
	output logic o_load_done
);

	import mk14_pkg::*;

	ihex_state_e state;

	logic second_digit;	// Next digit completes a byte
	logic [3:0] hi_nib;
	byte_t byte_cnt;	// Data bytes left in record
	byte_t rec_type;
	addr_t rec_addr;
	byte_t sum;	// Running modulo-256 sum

	logic [4:0] nib_dec;
	logic nib_valid;
	logic [3:0] nib_val;
	byte_t cur_byte;
	byte_t sum_next;

	// Returns {valid, value} for one ASCII hex digit
	function automatic logic [4:0] hex_nibble(input byte_t c);
		logic [4:0] r;
		r = 5'b0;
		if (c >= "0" && c <= "9") begin
			r = {1'b1, c[3:0]};
		end else if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f")) begin
			r = {1'b1, c[3:0] + 4'd9};	// Low nibble of 'A' and 'a' is 1
		end
		return r;
	endfunction

	always_comb begin
		nib_dec = hex_nibble(i_rx_data);
		nib_valid = nib_dec[4];
		nib_val = nib_dec[3:0];
		cur_byte = {hi_nib, nib_val};
		sum_next = sum + cur_byte;
	end

	assign o_loading = (state != IH_DONE);

	always_ff @(posedge clk) begin
		o_wr_en <= 1'b0;
		o_load_done <= 1'b0;
		if (soft_reset) begin
			state <= IH_SCAN;
			second_digit <= 1'b0;
			o_load_error <= 1'b0;
		end else if (i_rx_valid && o_loading) begin
			if (state == IH_SCAN) begin
				if (i_rx_data == ":") begin	// Start of record
					state <= IH_COUNT;
					second_digit <= 1'b0;
					sum <= '0;
				end
			end else if (!nib_valid) begin
				o_load_error <= 1'b1;
				state <= IH_SCAN;
			end else if (!second_digit) begin
				hi_nib <= nib_val;
				second_digit <= 1'b1;
			end else begin
				second_digit <= 1'b0;
				sum <= sum_next;
				case (state)
				IH_COUNT: begin
					byte_cnt <= cur_byte;
					state <= IH_ADDR_HI;
				end
				IH_ADDR_HI: begin
					rec_addr[15:8] <= cur_byte;
					state <= IH_ADDR_LO;
				end
				IH_ADDR_LO: begin
					rec_addr[7:0] <= cur_byte;
					state <= IH_TYPE;
				end
				IH_TYPE: begin
					rec_type <= cur_byte;
					if (byte_cnt == '0)
						state <= IH_CSUM;
					else
						state <= IH_DATA;
				end
				IH_DATA: begin
					if (rec_type == 8'h00) begin	// Only data records reach RAM
						o_wr_en <= 1'b1;
						o_wr_addr <= rec_addr;
						o_wr_data <= cur_byte;
					end
					rec_addr <= rec_addr + 16'd1;
					byte_cnt <= byte_cnt - 8'd1;
					if (byte_cnt == 8'd1)
						state <= IH_CSUM;
				end
				IH_CSUM: begin
					// Sum of all record bytes including checksum is zero
					if (sum_next != '0)
						o_load_error <= 1'b1;
					if (rec_type == 8'h01) begin	// End of file
						o_load_done <= 1'b1;
						state <= IH_DONE;
					end else begin
						state <= IH_SCAN;
					end
				end
				default:
					state <= IH_SCAN;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: src/ir_keymap.sv
// Maps decoded remote codes onto the keypad matrix as a press, a timed hold and a release

`default_nettype none
`timescale 1ns/1ps

module ir_keymap (
	input wire logic clk,
	input wire logic soft_reset,
	input wire logic i_en,
	input wire mk14_pkg::ir_code_t i_ir_code,
	input wire logic i_ir_valid,
	output logic o_kbd_wr,
	output mk14_pkg::kbd_row_t o_kbd_row,
	output mk14_pkg::kbd_bit_t o_kbd_bit,
	output logic o_kbd_pressed
);

	import mk14_pkg::*;

	key_state_e state;
	ir_code_t saved_code;
	logic [$clog2(KEY_HOLD_CYCLES)-1:0] hold_cnt;
	logic hit;	// Saved code is in the table

	always_comb begin
		hit = 1'b1;
		o_kbd_row = '0;
		o_kbd_bit = '0;
		case (saved_code)
		8'hBA: begin o_kbd_row = 3'd3; o_kbd_bit = 3'd5; end	// OK => MEM
		8'h70: begin o_kbd_row = 3'd7; o_kbd_bit = 3'd5; end	// Audio => TERM
		8'h32: begin o_kbd_row = 3'd2; o_kbd_bit = 3'd5; end	// Menu => GO
		8'h02: begin o_kbd_row = 3'd4; o_kbd_bit = 3'd5; end	// Exit => ABORT
		8'h58: begin o_kbd_row = 3'd0; o_kbd_bit = 3'd7; end	// 0
		8'hC8: begin o_kbd_row = 3'd1; o_kbd_bit = 3'd7; end
		8'hD8: begin o_kbd_row = 3'd2; o_kbd_bit = 3'd7; end
		8'hE0: begin o_kbd_row = 3'd3; o_kbd_bit = 3'd7; end
		8'hE8: begin o_kbd_row = 3'd4; o_kbd_bit = 3'd7; end
		8'hF8: begin o_kbd_row = 3'd5; o_kbd_bit = 3'd7; end	// 5
		8'hC0: begin o_kbd_row = 3'd6; o_kbd_bit = 3'd7; end
		8'h68: begin o_kbd_row = 3'd7; o_kbd_bit = 3'd7; end
		8'h78: begin o_kbd_row = 3'd0; o_kbd_bit = 3'd6; end	// 8
		8'h40: begin o_kbd_row = 3'd1; o_kbd_bit = 3'd6; end	// 9
		8'h12: begin o_kbd_row = 3'd0; o_kbd_bit = 3'd4; end	// A
		8'h0A: begin o_kbd_row = 3'd1; o_kbd_bit = 3'd4; end
		8'h2A: begin o_kbd_row = 3'd2; o_kbd_bit = 3'd4; end
		8'h1A: begin o_kbd_row = 3'd3; o_kbd_bit = 3'd4; end
		8'h22: begin o_kbd_row = 3'd6; o_kbd_bit = 3'd4; end
		8'h3A: begin o_kbd_row = 3'd7; o_kbd_bit = 3'd4; end	// F
		default:
			hit = 1'b0;
		endcase
	end

	assign o_kbd_pressed = (state == KEY_PRESS);
	assign o_kbd_wr = ((state == KEY_PRESS) && hit) || ((state == KEY_HOLD) && (hold_cnt == '0));

	always_ff @(posedge clk) begin
		if (soft_reset) begin
			state <= KEY_IDLE;
		end else begin
			case (state)
			KEY_IDLE: begin
				if (i_en && i_ir_valid) begin
					saved_code <= i_ir_code;
					state <= KEY_PRESS;
				end
			end
			KEY_PRESS: begin
				hold_cnt <= KEY_HOLD_CYCLES[$clog2(KEY_HOLD_CYCLES)-1:0] - 1'b1;
				state <= hit ? KEY_HOLD : KEY_IDLE;	// Unknown code drops out
			end
			KEY_HOLD: begin
				hold_cnt <= hold_cnt - 1'b1;
				if (hold_cnt == '0)	// Release write this cycle
					state <= KEY_IDLE;
			end
			default:
				state <= KEY_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/mk14_memmap.sv
// Standard RAM and active-low keypad rows sharing one registered read port

`default_nettype none
`timescale 1ns/1ps

module mk14_memmap (
	input wire logic clk,
	input wire logic soft_reset,
	input wire logic i_wr_en,
	input wire mk14_pkg::addr_t i_wr_addr,
	input wire mk14_pkg::byte_t i_wr_data,
	input wire logic i_kbd_wr,
	input wire mk14_pkg::kbd_row_t i_kbd_row,
	input wire mk14_pkg::kbd_bit_t i_kbd_bit,
	input wire logic i_kbd_pressed,
	input wire mk14_pkg::addr_t i_rd_addr,
	output mk14_pkg::byte_t o_rd_data
);

	import mk14_pkg::*;

	localparam int RAM_AW = $clog2(RAM_SIZE);

	byte_t ram [RAM_SIZE];
	byte_t kbd_rows [KBD_ROWS];	// Bit low while key is down

	addr_t wr_off;
	addr_t rd_ram_off;
	addr_t rd_kbd_off;
	logic wr_in_ram;
	logic rd_in_ram;
	logic rd_in_kbd;

	always_comb begin
		wr_off = i_wr_addr - RAM_BASE;
		rd_ram_off = i_rd_addr - RAM_BASE;
		rd_kbd_off = i_rd_addr - KBD_BASE;
		wr_in_ram = (wr_off < RAM_SIZE);	// Wraps below base too
		rd_in_ram = (rd_ram_off < RAM_SIZE);
		rd_in_kbd = (rd_kbd_off < KBD_ROWS);
	end

	always_ff @(posedge clk) begin
		if (i_wr_en && wr_in_ram)
			ram[wr_off[RAM_AW-1:0]] <= i_wr_data;
	end

	always_ff @(posedge clk) begin
		if (soft_reset) begin
			for (int i = 0; i < KBD_ROWS; i++)
				kbd_rows[i] <= 8'hFF;
		end else if (i_kbd_wr) begin
			kbd_rows[i_kbd_row][i_kbd_bit] <= ~i_kbd_pressed;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_in_ram)
			o_rd_data <= ram[rd_ram_off[RAM_AW-1:0]];
		else if (rd_in_kbd)
			o_rd_data <= kbd_rows[rd_kbd_off[2:0]];
		else
			o_rd_data <= 8'hFF;	// Unmapped
	end

endmodule

`default_nettype wire

// File: src/mk14_loader_top.sv
// Top level of the HEX loader and IR keypad front end; exposes the processor-side read port

`default_nettype none
`timescale 1ns/1ps

module mk14_loader_top (
	input wire logic clk,
	input wire logic soft_reset,
	input wire mk14_pkg::byte_t i_rx_data,
	input wire logic i_rx_valid,
	input wire mk14_pkg::ir_code_t i_ir_code,
	input wire logic i_ir_valid,
	input wire mk14_pkg::addr_t i_rd_addr,
	output mk14_pkg::byte_t o_rd_data,
	output logic o_loading,
	output logic o_load_error,
	output logic o_load_done
);

	import mk14_pkg::*;

	logic wr_en;
	addr_t wr_addr;
	byte_t wr_data;

	logic kbd_wr;
	kbd_row_t kbd_row;
	kbd_bit_t kbd_bit;
	logic kbd_pressed;

	ihex_loader loader_inst (
		.clk,
		.soft_reset,
		.i_rx_data,
		.i_rx_valid,
		.o_wr_en(wr_en),
		.o_wr_addr(wr_addr),
		.o_wr_data(wr_data),
		.o_loading,
		.o_load_error,
		.o_load_done
	);

	ir_keymap keymap_inst (
		.clk,
		.soft_reset,
		.i_en(!o_loading),	// Keys only after load mode
		.i_ir_code,
		.i_ir_valid,
		.o_kbd_wr(kbd_wr),
		.o_kbd_row(kbd_row),
		.o_kbd_bit(kbd_bit),
		.o_kbd_pressed(kbd_pressed)
	);

	mk14_memmap memmap_inst (
		.clk,
		.soft_reset,
		.i_wr_en(wr_en),
		.i_wr_addr(wr_addr),
		.i_wr_data(wr_data),
		.i_kbd_wr(kbd_wr),
		.i_kbd_row(kbd_row),
		.i_kbd_bit(kbd_bit),
		.i_kbd_pressed(kbd_pressed),
		.i_rd_addr,
		.o_rd_data
	);

endmodule

`default_nettype wire

// File: bench/mk14_loader_chk.sv
// Concurrent assertions for the loader top level, attached to every instance through bind

`default_nettype none
`timescale 1ns/1ps

module mk14_loader_chk (
	input wire logic clk,
	input wire logic soft_reset,
	input wire logic i_loading,
	input wire logic i_load_done,
	input wire logic i_kbd_pressed,
	input wire logic i_wr_en,
	input wire mk14_pkg::addr_t i_wr_addr
);

	// Keypad stays quiet until the HEX load is over
	no_press_while_loading: assert property (@(posedge clk) disable iff (soft_reset)
		!(i_loading && i_kbd_pressed))
		else $error("keypad press seen while still in load mode");

	done_single_cycle: assert property (@(posedge clk) disable iff (soft_reset)
		i_load_done |=> !i_load_done)
		else $error("load done pulse longer than one cycle");

	ram_write_addr_known: assert property (@(posedge clk) disable iff (soft_reset)
		i_wr_en |-> !$isunknown(i_wr_addr))
		else $error("RAM write strobe with unknown address");

endmodule

bind mk14_loader_top mk14_loader_chk chk_inst (
	.clk(clk),
	.soft_reset(soft_reset),
	.i_loading(o_loading),
	.i_load_done(o_load_done),
	.i_kbd_pressed(kbd_pressed),
	.i_wr_en(wr_en),
	.i_wr_addr(wr_addr)
);

`default_nettype wire

// File: bench/tb_mk14_loader.sv
// Directed testbench for the HEX loader and IR keypad front end; top module of the simulation

`default_nettype none
`timescale 1ns/1ps

module tb_mk14_loader;

	import mk14_pkg::*;

	localparam int WAIT_LIMIT = 200;	// Cycles allowed per wait

	logic clk;
	logic soft_reset;
	byte_t i_rx_data;
	logic i_rx_valid;
	ir_code_t i_ir_code;
	logic i_ir_valid;
	addr_t i_rd_addr;
	byte_t o_rd_data;
	logic o_loading;
	logic o_load_error;
	logic o_load_done;

	byte_t ram_model [RAM_SIZE];
	addr_t known_addrs [$];	// RAM locations written so far
	byte_t rec_data [$];
	int wr_count;
	int done_count;
	int kbd_wr_count;
	int cycle_count;
	int test_errors;
	int errors;
	int tests_failed;

	mk14_loader_top DUT (
		.clk(clk),
		.soft_reset(soft_reset),
		.i_rx_data(i_rx_data),
		.i_rx_valid(i_rx_valid),
		.i_ir_code(i_ir_code),
		.i_ir_valid(i_ir_valid),
		.i_rd_addr(i_rd_addr),
		.o_rd_data(o_rd_data),
		.o_loading(o_loading),
		.o_load_error(o_load_error),
		.o_load_done(o_load_done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) cycle_count = cycle_count + 1;

	// Strobe counters sampled mid-cycle
	always @(negedge clk) begin
		if (DUT.wr_en === 1'b1) wr_count = wr_count + 1;
		if (o_load_done === 1'b1) done_count = done_count + 1;
		if (DUT.kbd_wr === 1'b1) kbd_wr_count = kbd_wr_count + 1;
	end

	task automatic log_error(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		test_errors++;
	endtask

	task automatic close_test(input string name);
		if (test_errors == 0) begin
			$display("PASS  %s", name);
		end else begin
			$display("FAIL  %s (%0d errors)", name, test_errors);
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	function automatic byte_t hex_char(input logic [3:0] n);
		if (n < 4'd10)
			return 8'h30 + {4'h0, n};
		return 8'h37 + {4'h0, n};	// 'A' for 10
	endfunction

	task automatic send_char(input byte_t c);
		@(posedge clk);
		i_rx_data <= c;
		i_rx_valid <= 1'b1;
		@(posedge clk);
		i_rx_valid <= 1'b0;
	endtask

	task automatic send_hex_byte(input byte_t b);
		send_char(hex_char(b[7:4]));
		send_char(hex_char(b[3:0]));
	endtask

	// One record from rec_data, checksum is two's complement of the byte sum
	task automatic send_record(input byte_t rec_type, input addr_t addr, input logic bad_sum);
		byte_t sum;
		byte_t count;
		count = byte_t'(rec_data.size());
		sum = count + addr[15:8] + addr[7:0] + rec_type;
		foreach (rec_data[i])
			sum += rec_data[i];
		send_char(":");
		send_hex_byte(count);
		send_hex_byte(addr[15:8]);
		send_hex_byte(addr[7:0]);
		send_hex_byte(rec_type);
		foreach (rec_data[i])
			send_hex_byte(rec_data[i]);
		send_hex_byte(bad_sum ? (8'h00 - sum) ^ 8'h5A : 8'h00 - sum);
		send_char(8'h0D);
		send_char(8'h0A);
	endtask

	// Data bytes land at consecutive addresses when inside the RAM window
	task automatic model_data_record(input addr_t addr);
		addr_t a;
		foreach (rec_data[i]) begin
			a = addr + addr_t'(i);
			if (a >= RAM_BASE && a < RAM_BASE + RAM_SIZE) begin
				ram_model[a - RAM_BASE] = rec_data[i];
				known_addrs.push_back(a);
			end
		end
	endtask

	task automatic fill_random(input int n);
		logic [31:0] rnd;
		rec_data.delete();
		repeat (n) begin
			rnd = $urandom();
			rec_data.push_back(rnd[7:0]);
		end
	endtask

	task automatic read_byte(input addr_t addr, output byte_t data);
		@(posedge clk);
		i_rd_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		data = o_rd_data;
	endtask

	task automatic wait_writes(input int target);
		int n;
		n = 0;
		while (wr_count < target && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (wr_count != target)
			log_error($sformatf("saw %0d RAM writes, expected %0d", wr_count, target));
	endtask

	task automatic check_ram();
		byte_t d;
		foreach (known_addrs[i]) begin
			read_byte(known_addrs[i], d);
			if (d !== ram_model[known_addrs[i] - RAM_BASE])
				log_error($sformatf("RAM 0x%04h read 0x%02h, expected 0x%02h",
					known_addrs[i], d, ram_model[known_addrs[i] - RAM_BASE]));
		end
	endtask

	task automatic check_rows_idle();
		byte_t d;
		for (int r = 0; r < 8; r++) begin
			read_byte(KBD_BASE + addr_t'(r), d);
			if (d !== 8'hFF)
				log_error($sformatf("keypad row %0d read 0x%02h, expected 0xFF", r, d));
		end
	endtask

	// Polls a keypad row until it reads exp; reports the cycle it was seen
	task automatic wait_row(input int row, input byte_t exp, input int limit, output int seen);
		byte_t d;
		int n;
		n = 0;
		read_byte(KBD_BASE + addr_t'(row), d);
		while (d !== exp && n < limit) begin
			read_byte(KBD_BASE + addr_t'(row), d);
			n++;
		end
		seen = cycle_count;
		if (d !== exp) begin
			$display("Timeout waiting for keypad row %0d to read 0x%02h", row, exp);
			test_errors++;
		end
	endtask

	task automatic send_ir(input ir_code_t code);
		@(posedge clk);
		i_ir_code <= code;
		i_ir_valid <= 1'b1;
		@(posedge clk);
		i_ir_valid <= 1'b0;
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		if (o_loading !== 1'b1) log_error("o_loading not high after reset");
		if (o_load_error !== 1'b0) log_error("o_load_error set after reset");
		if (o_load_done !== 1'b0) log_error("o_load_done set after reset");
		check_rows_idle();
		close_test("reset state");
	endtask

	task automatic test_ir_in_load_mode();
		int start;
		start = kbd_wr_count;
		send_ir(8'hF8);
		repeat (KEY_HOLD_CYCLES / 2) @(posedge clk);	// Any press would be visible by now
		if (kbd_wr_count != start) log_error("keypad written during load mode");
		check_rows_idle();
		close_test("IR code ignored in load mode");
	endtask

	task automatic test_data_record();
		int start;
		start = wr_count;
		fill_random(16);
		send_record(8'h00, 16'h0F20, 1'b0);
		model_data_record(16'h0F20);
		wait_writes(start + 16);
		@(negedge clk);
		if (o_load_error !== 1'b0) log_error("o_load_error set by a valid record");
		check_ram();
		close_test("data record at 0x0F20");
	endtask

	task automatic test_bad_records();
		int start;
		int n;
		byte_t d;
		start = wr_count;
		fill_random(4);
		send_record(8'h00, 16'h0F00, 1'b0);	// Same low address bits as 0x0500
		model_data_record(16'h0F00);
		wait_writes(start + 4);
		start = wr_count;
		fill_random(4);
		send_record(8'h00, 16'h0500, 1'b0);	// Outside the RAM window
		wait_writes(start + 4);
		read_byte(16'h0500, d);
		if (d !== 8'hFF) log_error($sformatf("0x0500 read 0x%02h, expected 0xFF", d));
		if (o_load_error !== 1'b0) log_error("o_load_error set by record at 0x0500");
		check_ram();
		fill_random(2);
		send_record(8'h00, 16'h0F40, 1'b1);
		model_data_record(16'h0F40);
		n = 0;
		while (o_load_error !== 1'b1 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (o_load_error !== 1'b1) log_error("o_load_error not set by a bad checksum");
		check_ram();
		close_test("unmapped record and bad checksum");
	endtask

	task automatic test_end_of_file();
		int start_done;
		int start_wr;
		int n;
		start_done = done_count;
		rec_data.delete();
		send_record(8'h01, 16'h0000, 1'b0);
		n = 0;
		while (done_count == start_done && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (done_count == start_done) begin
			$display("Timeout waiting for the end-of-file done pulse");
			test_errors++;
		end
		@(negedge clk);
		if (o_loading !== 1'b0) log_error("o_loading still high after end of file");
		if (done_count != start_done + 1) log_error("o_load_done was not a single pulse");
		start_wr = wr_count;
		fill_random(4);
		send_record(8'h00, 16'h0F60, 1'b0);
		repeat (4) @(posedge clk);
		if (wr_count != start_wr) log_error("RAM written after end of file");
		close_test("end of file");
	endtask

	task automatic test_keypad();
		int start;
		int t_press;
		int t_release;
		start = kbd_wr_count;
		send_ir(8'hF8);	// Digit 5
		wait_row(5, 8'h7F, WAIT_LIMIT, t_press);
		wait_row(5, 8'hFF, KEY_HOLD_CYCLES + 8, t_release);
		if (t_release - t_press < KEY_HOLD_CYCLES - 2 || t_release - t_press > KEY_HOLD_CYCLES + 2)
			log_error($sformatf("key held %0d cycles", t_release - t_press));
		if (kbd_wr_count != start + 2) log_error("expected one press and one release write");
		start = kbd_wr_count;
		send_ir(8'h55);	// Not in the table
		repeat (8) @(posedge clk);
		if (kbd_wr_count != start) log_error("unknown IR code wrote the keypad");
		check_rows_idle();
		close_test("IR keypad press and release");
	endtask

	initial begin
		soft_reset = 1'b1;
		i_rx_data = '0;
		i_rx_valid = 1'b0;
		i_ir_code = '0;
		i_ir_valid = 1'b0;
		i_rd_addr = '0;
		wr_count = 0;
		done_count = 0;
		kbd_wr_count = 0;
		cycle_count = 0;
		test_errors = 0;
		errors = 0;
		tests_failed = 0;
		void'($urandom(32'h3955622d));
		repeat (16) @(posedge clk);
		soft_reset <= 1'b0;
		@(posedge clk);
		test_reset_state();
		test_ir_in_load_mode();
		test_data_record();
		test_bad_records();
		test_end_of_file();
		test_keypad();
		$display("Tests: 6, failed: %0d, errors: %0d", tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#200000;
		$display("Run time limit reached before all tests finished");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
src/mk14_pkg.sv
src/ihex_loader.sv
src/ir_keymap.sv
src/mk14_memmap.sv
src/mk14_loader_top.sv
bench/mk14_loader_chk.sv
bench/tb_mk14_loader.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mk14_loader -f build.f -o sim_mk14

./obj_dir/sim_mk14 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
	echo "Result: PASS"
	exit 0
else
	echo "Result: FAIL"
	exit 1
fi
